// File: dv/serial_loader_tb.sv
`timescale 1ns/1ps
`default_nettype none

module serial_loader_tb import uart_pkg::*, loader_pkg::*; ();

    localparam int cycle_limit = 20000; // about 45 frames of 160 cycles doubled plus margin
    localparam int frame_cycles = frame_bits * clks_per_bit;

    logic clk = 1'b0;
    logic reset_n, rxd;
    logic send_boot_request, receive_size, receive_program;
    logic send_load_done, receive_stdin, send_stdout;
    logic stdout_ready;
    logic [7:0] stdout_rdata;
    wire txd, frame_error, boot_request_done, size_done, program_done, load_done_sent;
    wire prog_we, stdin_we, stdout_rd;
    wire [prog_addr_width-1:0] prog_addr;
    wire [31:0] prog_wdata;
    wire [7:0] stdin_wdata;

    int cycles = 0;
    int err_count = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int frame_errors = 0;
    logic [7:0] tx_seen[$];       // bytes captured from txd
    logic [7:0] stdout_model[$];  // stdout buffer contents
    logic [7:0] stdin_expect[$];
    logic [31:0] word_expect[$];
    logic [prog_addr_width-1:0] addr_expect[$];
    logic [31:0] prog_mem[0:15];

    serial_loader_top serial_loader_top_inst (.*);

    always #10 clk = ~clk;

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("Fail at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        err_count++;
    endtask

    task automatic report_problem(string what);
        $display("Error at %0t ns: %s", $time, what);
        err_count++;
    endtask

    task automatic close_test(string name, int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    // host side serial driver sends lsb first
    task automatic send_frame(logic [7:0] data, logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, data, 1'b0};
        for (int i = 0; i < frame_bits; i++) begin
            rxd <= bits[i];
            repeat (clks_per_bit) @(posedge clk);
        end
        rxd <= 1'b1;
        @(posedge clk);
    endtask

    task automatic idle_frames(int n);
        repeat (n * frame_cycles) @(posedge clk);
    endtask

    // txd capture samples at bit middles
    initial begin
        logic [7:0] b;
        forever begin
            @(posedge clk);
            if (reset_n && !txd) begin
                repeat (clks_per_bit / 2) @(posedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (clks_per_bit) @(posedge clk);
                    b[i] = txd;
                end
                repeat (clks_per_bit) @(posedge clk);
                assert (txd) else report_problem("transmitted frame has a low stop bit");
                tx_seen.push_back(b);
            end
        end
    end

    // memory models and write checks
    always @(posedge clk) begin
        if (frame_error) frame_errors++;
        if (prog_we) begin
            prog_mem[prog_addr[5:2]] = prog_wdata;
            assert (word_expect.size() > 0) else report_problem("unexpected prog_we");
            if (word_expect.size() > 0) begin
                assert (prog_addr == addr_expect[0])
                    else report_mismatch("prog_addr", addr_expect[0], prog_addr);
                assert (prog_wdata == word_expect[0])
                    else report_mismatch("prog_wdata", word_expect[0], prog_wdata);
                void'(word_expect.pop_front());
                void'(addr_expect.pop_front());
            end
        end
        if (stdin_we) begin
            assert (stdin_expect.size() > 0) else report_problem("unexpected stdin_we");
            if (stdin_expect.size() > 0) begin
                assert (stdin_wdata == stdin_expect[0])
                    else report_mismatch("stdin_wdata", stdin_expect[0], stdin_wdata);
                void'(stdin_expect.pop_front());
            end
        end
        if (!reset_n) begin
            stdout_ready <= 1'b0;
        end else begin
            if (stdout_rd && stdout_model.size() > 0) void'(stdout_model.pop_front());
            stdout_rdata <= (stdout_model.size() > 0) ? stdout_model[0] : 8'h00;
            stdout_ready <= (stdout_model.size() > 0) && ($urandom % 4 != 0); // withheld at random
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Error: run stopped after %0d cycles, DUT did not respond", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    a_stdout_rd_ready: assert property (@(posedge clk) disable iff (!reset_n)
        stdout_rd |-> stdout_ready) else report_problem("stdout_rd while stdout_ready low");
    a_boot_done_holds: assert property (@(posedge clk) disable iff (!reset_n)
        boot_request_done && send_boot_request |=> boot_request_done)
        else report_problem("boot_request_done dropped while commanded");
    a_load_done_holds: assert property (@(posedge clk) disable iff (!reset_n)
        load_done_sent && send_load_done |=> load_done_sent)
        else report_problem("load_done_sent dropped while commanded");

    initial begin
        int errs;
        program_word_t w;
        logic [7:0] b;
        logic [7:0] sent[$];
        logic [31:0] image[$];
        void'($urandom(80));
        reset_n = 1'b0;
        rxd = 1'b1;
        {send_boot_request, receive_size, receive_program} = '0;
        {send_load_done, receive_stdin, send_stdout} = '0;
        stdout_ready = 1'b0;
        stdout_rdata = 8'h00;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        repeat (4) @(posedge clk);

        errs = err_count; // boot request
        send_boot_request <= 1'b1;
        while (!boot_request_done) @(posedge clk);
        while (tx_seen.size() < 1) @(posedge clk);
        idle_frames(2);
        assert (tx_seen.size() == 1) else report_mismatch("tx frame count", 1, tx_seen.size());
        assert (tx_seen[0] == boot_request_byte)
            else report_mismatch("txd byte", boot_request_byte, tx_seen[0]);
        send_boot_request <= 1'b0;
        repeat (2) @(posedge clk);
        assert (!boot_request_done) else report_problem("boot_request_done stuck high");
        tx_seen.delete();
        close_test("boot request", errs);

        errs = err_count; // program size of 12 bytes
        receive_size <= 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < 4; i++) begin
            assert (!size_done) else report_mismatch("size_done", 0, size_done);
            send_frame(i == 0 ? 8'd12 : 8'd0, 1'b1);
        end
        while (!size_done) @(posedge clk);
        receive_size <= 1'b0;
        repeat (2) @(posedge clk);
        close_test("program size", errs);

        errs = err_count; // program image
        receive_program <= 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < 12; i++) begin
            b = 8'($urandom);
            w.lane[i % 4] = b;
            if (i % 4 == 3) begin
                word_expect.push_back(w.word);
                image.push_back(w.word);
                addr_expect.push_back(prog_addr_width'(i - 3));
            end
            assert (!program_done) else report_mismatch("program_done", 0, program_done);
            send_frame(b, 1'b1);
        end
        while (!program_done) @(posedge clk);
        assert (word_expect.size() == 0)
            else report_mismatch("missing prog_we", 0, word_expect.size());
        for (int i = 0; i < 3; i++) begin
            assert (prog_mem[i] == image[i])
                else report_mismatch("prog_mem", image[i], prog_mem[i]);
        end
        receive_program <= 1'b0;
        repeat (2) @(posedge clk);
        close_test("program image", errs);

        errs = err_count; // stdin then stdout
        receive_stdin <= 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < 4; i++) begin
            b = 8'($urandom);
            stdin_expect.push_back(b);
            send_frame(b, 1'b1);
        end
        while (stdin_expect.size() > 0) @(posedge clk);
        receive_stdin <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < 5; i++) begin
            b = 8'($urandom);
            stdout_model.push_back(b);
            sent.push_back(b);
        end
        send_stdout <= 1'b1;
        while (tx_seen.size() < 5) @(posedge clk);
        send_stdout <= 1'b0;
        idle_frames(1);
        assert (tx_seen.size() == 5) else report_mismatch("tx frame count", 5, tx_seen.size());
        for (int i = 0; i < 5; i++) begin
            assert (tx_seen[i] == sent[i]) else report_mismatch("txd byte", sent[i], tx_seen[i]);
        end
        tx_seen.delete();
        close_test("console traffic", errs);

        errs = err_count; // load done
        send_load_done <= 1'b1;
        while (!load_done_sent) @(posedge clk);
        while (tx_seen.size() < 1) @(posedge clk);
        idle_frames(2);
        assert (tx_seen.size() == 1) else report_mismatch("tx frame count", 1, tx_seen.size());
        assert (tx_seen[0] == load_done_byte)
            else report_mismatch("txd byte", load_done_byte, tx_seen[0]);
        send_load_done <= 1'b0;
        repeat (2) @(posedge clk);
        close_test("load done", errs);

        errs = err_count; // bad stop bit must not reach stdin
        receive_stdin <= 1'b1;
        repeat (2) @(posedge clk);
        send_frame(8'h5A, 1'b0);
        idle_frames(1);
        assert (frame_errors == 1) else report_mismatch("frame_error pulses", 1, frame_errors);
        receive_stdin <= 1'b0;
        close_test("frame error", errs);

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the serial loader testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module serial_loader_tb -f src.f > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vserial_loader_tb > sim.log 2>&1 || echo "simulator returned an error"

grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log && { echo "simulation passed"; exit 0; } \
    || { echo "no result in sim.log"; exit 1; }

// File: source/loader_controller.sv
`timescale 1ns/1ps
`default_nettype none

module loader_controller import loader_pkg::*; (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic [7:0]                 rx_data,
    input  logic                       rx_valid,
    input  logic                       send_boot_request,
    input  logic                       receive_size,
    input  logic                       receive_program,
    input  logic                       send_load_done,
    input  logic                       receive_stdin,
    input  logic                       send_stdout,
    input  logic                       stdout_ready,
    input  logic [7:0]                 stdout_rdata,
    input  logic                       tx_busy,
    output logic                       boot_request_done,
    output logic                       size_done,
    output logic                       program_done,
    output logic                       load_done_sent,
    output logic                       prog_we,
    output logic [prog_addr_width-1:0] prog_addr,
    output logic [31:0]                prog_wdata,
    output logic                       stdin_we,
    output logic [7:0]                 stdin_wdata,
    output logic                       stdout_rd,
    output logic [7:0]                 tx_data,
    output logic                       tx_start
);

    logic [5:0]                 cmd;
    logic [5:0]                 cmd_q;
    logic [1:0]                 lane;
    program_word_t              word_buf;
    program_word_t              word_next;
    logic [31:0]                prog_size;
    logic [31:0]                byte_count;
    logic [prog_addr_width-1:0] wr_addr;
    logic                       last_lane;
    logic                       tx_free;
    logic                       send_done_byte;
    logic                       send_boot_byte;

    assign cmd = {send_boot_request, receive_size, receive_program,
                  send_load_done, receive_stdin, send_stdout};
    assign last_lane = (lane == 2'd3);

    always_comb begin
        word_next = word_buf;
        word_next.lane[lane] = rx_data;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            cmd_q <= '0;
            lane <= '0;
            prog_size <= '0;
            byte_count <= '0;
            wr_addr <= '0;
            size_done <= 1'b0;
            program_done <= 1'b0;
            prog_we <= 1'b0;
            stdin_we <= 1'b0;
        end else begin
            cmd_q <= cmd;
            prog_we <= 1'b0;
            stdin_we <= 1'b0;
            if (!receive_size) begin
                size_done <= 1'b0;
            end
            if (!receive_program) begin
                program_done <= 1'b0;
                byte_count <= '0;
                wr_addr <= '0; // image always loads from address 0
            end
            if (cmd != cmd_q) begin
                lane <= '0;
            end else if (rx_valid) begin
                if (receive_size && !size_done) begin
                    lane <= lane + 2'd1;
                    if (last_lane) begin
                        prog_size <= word_next.word;
                        size_done <= 1'b1;
                    end
                end else if (receive_program && !program_done) begin
                    lane <= lane + 2'd1;
                    byte_count <= byte_count + 32'd1;
                    if (last_lane) begin
                        prog_we <= 1'b1;
                        wr_addr <= wr_addr + prog_addr_width'(4);
                    end
                    if (byte_count + 32'd1 == prog_size) begin
                        program_done <= 1'b1;
                    end
                end else if (receive_stdin) begin
                    stdin_we <= 1'b1; // stdin buffer never stalls
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            word_buf <= word_next;
            stdin_wdata <= rx_data;
        end
        if (rx_valid && receive_program && last_lane) begin
            prog_addr <= wr_addr;
            prog_wdata <= word_next.word;
        end
    end

    // transmit arbitration, stdout first
    assign tx_free = !tx_busy && !tx_start;
    assign stdout_rd = tx_free && send_stdout && stdout_ready;
    assign send_done_byte = tx_free && send_load_done && !load_done_sent && !stdout_rd;
    assign send_boot_byte = tx_free && send_boot_request && !boot_request_done
                            && !stdout_rd && !send_done_byte;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            tx_start <= 1'b0;
            boot_request_done <= 1'b0;
            load_done_sent <= 1'b0;
        end else begin
            tx_start <= stdout_rd || send_done_byte || send_boot_byte;
            if (!send_boot_request) begin
                boot_request_done <= 1'b0;
            end else if (send_boot_byte) begin
                boot_request_done <= 1'b1;
            end
            if (!send_load_done) begin
                load_done_sent <= 1'b0;
            end else if (send_done_byte) begin
                load_done_sent <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stdout_rd) begin
            tx_data <= stdout_rdata;
        end else if (send_done_byte) begin
            tx_data <= load_done_byte;
        end else if (send_boot_byte) begin
            tx_data <= boot_request_byte;
        end
    end

    a_prog_we_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        prog_we |=> !prog_we);
    a_stdin_we_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        stdin_we |=> !stdin_we);
    a_stdout_rd_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        stdout_rd |=> !stdout_rd);
    // sequencer raises one phase at a time
    a_one_command: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0(cmd));

endmodule

`default_nettype wire

// File: source/loader_pkg.sv
`default_nettype none

package loader_pkg;

    // handshake bytes towards the host
    localparam logic [7:0] boot_request_byte = 8'h99;
    localparam logic [7:0] load_done_byte = 8'hAA;

    // program memory byte address
    localparam int prog_addr_width = 16;

    localparam int lane_count = 4;
    localparam int word_width = 8 * lane_count;

    // little endian, lane 0 holds the first byte on the wire
    typedef union packed {
        logic [word_width-1:0] word;
        logic [lane_count-1:0][7:0] lane;
    } program_word_t;

endpackage

`default_nettype wire

// File: source/serial_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module serial_loader_top import loader_pkg::*; (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       rxd,
    output logic                       txd,
    output logic                       frame_error,
    input  logic                       send_boot_request,
    input  logic                       receive_size,
    input  logic                       receive_program,
    input  logic                       send_load_done,
    input  logic                       receive_stdin,
    input  logic                       send_stdout,
    output logic                       boot_request_done,
    output logic                       size_done,
    output logic                       program_done,
    output logic                       load_done_sent,
    output logic                       prog_we,
    output logic [prog_addr_width-1:0] prog_addr,
    output logic [31:0]                prog_wdata,
    output logic                       stdin_we,
    output logic [7:0]                 stdin_wdata,
    input  logic                       stdout_ready,
    input  logic [7:0]                 stdout_rdata,
    output logic                       stdout_rd
);

    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;

    uart_rx uart_rx_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .rxd         (rxd),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .frame_error (frame_error) // dropped byte, reported only
    );

    loader_controller loader_controller_inst (
        .clk               (clk),
        .reset_n           (reset_n),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .send_boot_request (send_boot_request),
        .receive_size      (receive_size),
        .receive_program   (receive_program),
        .send_load_done    (send_load_done),
        .receive_stdin     (receive_stdin),
        .send_stdout       (send_stdout),
        .stdout_ready      (stdout_ready),
        .stdout_rdata      (stdout_rdata),
        .tx_busy           (tx_busy),
        .boot_request_done (boot_request_done),
        .size_done         (size_done),
        .program_done      (program_done),
        .load_done_sent    (load_done_sent),
        .prog_we           (prog_we),
        .prog_addr         (prog_addr),
        .prog_wdata        (prog_wdata),
        .stdin_we          (stdin_we),
        .stdin_wdata       (stdin_wdata),
        .stdout_rd         (stdout_rd),
        .tx_data           (tx_data),
        .tx_start          (tx_start)
    );

    uart_tx uart_tx_inst (
        .clk      (clk),
        .reset_n  (reset_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .txd      (txd)
    );

endmodule

`default_nettype wire

// File: source/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // one serial bit in clk cycles
    localparam int clks_per_bit = 16;

    // start + 8 data + stop
    localparam int frame_bits = 10;

    // start bit is checked at its middle
    localparam int half_bit = clks_per_bit / 2;

    localparam int bit_cnt_width = $clog2(clks_per_bit);
    localparam int bit_idx_width = $clog2(frame_bits);

    localparam logic [bit_cnt_width-1:0] last_cnt = bit_cnt_width'(clks_per_bit - 1);
    localparam logic [bit_cnt_width-1:0] mid_cnt = bit_cnt_width'(half_bit - 1);
    localparam logic [bit_idx_width-1:0] stop_idx = bit_idx_width'(frame_bits - 1);

endpackage

`default_nettype wire

// File: source/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       frame_error
);

    logic                     rxd_meta;
    logic                     rxd_sync;
    logic                     rxd_prev;
    logic                     active;
    logic [bit_cnt_width-1:0] cnt;
    logic [bit_idx_width-1:0] bit_idx; // 0 start, 1..8 data, last is stop
    logic [7:0]               shift;
    logic                     start_edge;

    assign start_edge = rxd_prev && !rxd_sync;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            active <= 1'b0;
            cnt <= '0;
            bit_idx <= '0;
            rx_valid <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            frame_error <= 1'b0;
            if (!active) begin
                if (start_edge) begin
                    active <= 1'b1;
                    cnt <= '0;
                    bit_idx <= '0;
                end
            end else if (bit_idx == '0) begin
                if (cnt == mid_cnt) begin
                    cnt <= '0;
                    if (rxd_sync) begin
                        active <= 1'b0; // glitch, not a start bit
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                    end
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end else if (cnt == last_cnt) begin
                cnt <= '0;
                if (bit_idx == stop_idx) begin
                    active <= 1'b0;
                    rx_valid <= rxd_sync;
                    frame_error <= !rxd_sync;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // data path, lsb first
    always_ff @(posedge clk) begin
        if (active && bit_idx != '0 && bit_idx != stop_idx && cnt == last_cnt) begin
            shift <= {rxd_sync, shift[7:1]};
        end
        if (active && bit_idx == stop_idx && cnt == last_cnt) begin
            rx_data <= shift;
        end
    end

    a_valid_xor_error: assert property (@(posedge clk) disable iff (!reset_n)
        !(rx_valid && frame_error));

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx_busy,
    output logic       txd
);

    logic [bit_cnt_width-1:0] cnt;
    logic [bit_idx_width-1:0] bit_idx;
    logic [8:0]               shift; // data then stop bit

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            tx_busy <= 1'b0;
            txd <= 1'b1;
            cnt <= '0;
            bit_idx <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy <= 1'b1;
                txd <= 1'b0; // start bit
                cnt <= '0;
                bit_idx <= '0;
            end
        end else if (cnt == last_cnt) begin
            cnt <= '0;
            if (bit_idx == stop_idx) begin
                tx_busy <= 1'b0;
                txd <= 1'b1;
            end else begin
                txd <= shift[0];
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start) begin
            shift <= {1'b1, tx_data};
        end else if (tx_busy && cnt == last_cnt) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

    // the controller must wait for the frame to finish
    a_no_start_when_busy: assert property (@(posedge clk) disable iff (!reset_n)
        tx_busy |-> !tx_start);

endmodule

`default_nettype wire

// File: src.f
source/uart_pkg.sv
source/loader_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/loader_controller.sv
source/serial_loader_top.sv
dv/serial_loader_tb.sv
